/* common/wave_pkg.sv */
package wave_pkg;

    // frame timing in clk cycles
    localparam int sclk_half  = 4;
    localparam int frame_bits = 16;
    localparam int frame_gap  = 8;
    localparam int pre_w      = $clog2(frame_gap > sclk_half ? frame_gap : sclk_half);

    localparam logic [1:0] dac_pd       = 2'b00; // normal operation
    localparam logic [2:0] adc_channel  = 3'd1;
    localparam logic [7:0] debug_filler = 8'hab;

    // round(127 * sin(2*pi*q/256)) for q 0 to 64
    localparam logic [7:0] sine_quarter [0:64] = '{
        8'd0,   8'd3,   8'd6,   8'd9,   8'd12,  8'd16,  8'd19,  8'd22,
        8'd25,  8'd28,  8'd31,  8'd34,  8'd37,  8'd40,  8'd43,  8'd46,
        8'd49,  8'd51,  8'd54,  8'd57,  8'd60,  8'd63,  8'd65,  8'd68,
        8'd71,  8'd73,  8'd76,  8'd78,  8'd81,  8'd83,  8'd85,  8'd88,
        8'd90,  8'd92,  8'd94,  8'd96,  8'd98,  8'd100, 8'd102, 8'd104,
        8'd106, 8'd107, 8'd109, 8'd111, 8'd112, 8'd113, 8'd115, 8'd116,
        8'd117, 8'd118, 8'd120, 8'd121, 8'd122, 8'd122, 8'd123, 8'd124,
        8'd125, 8'd125, 8'd126, 8'd126, 8'd126, 8'd127, 8'd127, 8'd127,
        8'd127
    };

    typedef struct packed {
        logic       ss;      // active low
        logic       sclk;    // idles high
        logic [3:0] bit_idx; // 15 down to 0
        logic       shift;   // strobe on sclk fall
        logic       sample;  // strobe on sclk rise
        logic       done;    // strobe at frame end
    } frame_t;

    typedef struct packed {
        logic [7:0] phase;
        logic [7:0] adc1;
        logic [7:0] adc2;
    } snap_t;

    typedef enum logic [1:0] {
        cmd_phase  = 2'd0,
        cmd_adc1   = 2'd1,
        cmd_adc2   = 2'd2,
        cmd_filler = 2'd3
    } debug_cmd_e;

endpackage

/* spi_frame/spi_frame_ctrl.sv */
`timescale 1ns/1ps

module spi_frame_ctrl (
    input  logic              clk,
    input  logic              arst_n,
    output wave_pkg::frame_t  frame
);

    typedef enum logic [1:0] {
        st_gap,
        st_low,
        st_high
    } state_e;

    localparam logic [wave_pkg::pre_w-1:0] gap_last  = wave_pkg::pre_w'(wave_pkg::frame_gap - 1);
    localparam logic [wave_pkg::pre_w-1:0] half_last = wave_pkg::pre_w'(wave_pkg::sclk_half - 1);
    localparam logic [3:0]                 first_bit = 4'(wave_pkg::frame_bits - 1);

    state_e                   state;
    logic [wave_pkg::pre_w-1:0] pre_cnt;
    wave_pkg::frame_t         frame_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state           <= st_gap;
            pre_cnt         <= '0;
            frame_q.ss      <= 1'b1;
            frame_q.sclk    <= 1'b1;
            frame_q.bit_idx <= first_bit;
            frame_q.shift   <= 1'b0;
            frame_q.sample  <= 1'b0;
            frame_q.done    <= 1'b0;
        end else begin
            frame_q.shift  <= 1'b0;
            frame_q.sample <= 1'b0;
            frame_q.done   <= frame_q.sample && (frame_q.bit_idx == 4'd0); // after last rise

            case (state)
                st_gap: begin
                    if (pre_cnt == gap_last) begin
                        pre_cnt         <= '0;
                        state           <= st_low;
                        frame_q.ss      <= 1'b0;
                        frame_q.sclk    <= 1'b0;
                        frame_q.bit_idx <= first_bit; // first bit already set up
                    end else begin
                        pre_cnt <= pre_cnt + 1'b1;
                    end
                end
                st_low: begin
                    if (pre_cnt == half_last) begin
                        pre_cnt        <= '0;
                        state          <= st_high;
                        frame_q.sclk   <= 1'b1;
                        frame_q.sample <= 1'b1;
                    end else begin
                        pre_cnt <= pre_cnt + 1'b1;
                    end
                end
                default: begin
                    if (pre_cnt == half_last) begin
                        pre_cnt <= '0;
                        if (frame_q.bit_idx == 4'd0) begin
                            state      <= st_gap;
                            frame_q.ss <= 1'b1; // sclk stays high
                        end else begin
                            state           <= st_low;
                            frame_q.sclk    <= 1'b0;
                            frame_q.bit_idx <= frame_q.bit_idx - 1'b1;
                            frame_q.shift   <= 1'b1;
                        end
                    end else begin
                        pre_cnt <= pre_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    assign frame = frame_q;

endmodule

/* rtl/sine_phase_gen.sv */
`timescale 1ns/1ps

module sine_phase_gen (
    input  logic             clk,
    input  logic             arst_n,
    input  wave_pkg::frame_t frame,
    output logic [7:0]       phase,
    output logic [7:0]       sine
);

    logic [7:0] phase_q;
    logic [1:0] quad;
    logic [5:0] low;
    logic [6:0] q_idx;
    logic [7:0] entry;
    logic [8:0] value;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase_q <= 8'd0;
        end else if (frame.done) begin
            phase_q <= phase_q + 8'd1; // wraps at 256
        end
    end

    // quarter-wave fold
    always_comb begin
        quad = phase_q[7:6];
        low  = phase_q[5:0];

        if (quad[0]) begin
            q_idx = 7'd64 - {1'b0, low}; // falling quarter
        end else begin
            q_idx = {1'b0, low};
        end

        entry = wave_pkg::sine_quarter[q_idx];

        if (quad[1]) begin
            value = 9'd128 - {1'b0, entry}; // negative half
        end else begin
            value = 9'd128 + {1'b0, entry};
        end

        if (value > 9'd255) begin
            sine = 8'hff;
        end else begin
            sine = value[7:0];
        end
    end

    assign phase = phase_q;

endmodule

/* rtl/dac_frame_shifter.sv */
`timescale 1ns/1ps

module dac_frame_shifter (
    input  logic             clk,
    input  logic             arst_n,
    input  wave_pkg::frame_t frame,
    input  logic [11:0]      code,
    output logic             mosi
);

    logic [15:0] word_q;

    // reloaded through the gap, so the word in flight is the one at ss fall
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            word_q <= 16'd0;
        end else if (frame.ss) begin
            word_q <= {wave_pkg::dac_pd, code, 2'b00};
        end else if (frame.shift) begin
            word_q <= {word_q[14:0], 1'b0}; // msb first
        end
    end

    assign mosi = ~frame.ss & word_q[15]; // low outside the frame

endmodule

/* rtl/adc_frame_sampler.sv */
`timescale 1ns/1ps

module adc_frame_sampler (
    input  logic             clk,
    input  logic             arst_n,
    input  wave_pkg::frame_t frame,
    input  logic             miso,
    output logic             mosi,
    output logic [7:0]       code
);

    logic [10:0] shift_q;
    logic [7:0]  code_q;

    // channel address on bits 13..11
    always_comb begin
        mosi = 1'b0;
        if (!frame.ss) begin
            case (frame.bit_idx)
                4'd13:   mosi = wave_pkg::adc_channel[2];
                4'd12:   mosi = wave_pkg::adc_channel[1];
                4'd11:   mosi = wave_pkg::adc_channel[0];
                default: mosi = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            shift_q <= 11'd0;
            code_q  <= 8'd0;
        end else if (frame.sample) begin
            shift_q <= {shift_q[9:0], miso};
            // word bits 11..4 hold the result at the last sample
            if (frame.bit_idx == 4'd0) begin
                code_q <= shift_q[10:3];
            end
        end
    end

    assign code = code_q; // valid in the done cycle

endmodule

/* debug/debug_spi_slave.sv */
`timescale 1ns/1ps

module debug_spi_slave (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       debug_ss,
    input  logic       debug_sclk,
    input  logic       debug_mosi,
    output logic       debug_miso,
    input  logic [7:0] reply,
    output logic [7:0] cmd,
    output logic       cmd_valid
);

    logic [1:0] ss_sync;
    logic [1:0] sclk_sync;
    logic [1:0] mosi_sync;
    logic       ss_prev;
    logic       sclk_prev;
    logic       ss_fall;
    logic       sclk_rise;
    logic       sclk_fall;
    logic [2:0] bit_cnt;
    logic [6:0] rx_q;
    logic [7:0] tx_q;
    logic [7:0] cmd_q;
    logic       cmd_valid_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ss_sync   <= 2'b11;
            sclk_sync <= 2'b00; // mode 0 idle
            mosi_sync <= 2'b00;
            ss_prev   <= 1'b1;
            sclk_prev <= 1'b0;
        end else begin
            ss_sync   <= {ss_sync[0], debug_ss};
            sclk_sync <= {sclk_sync[0], debug_sclk};
            mosi_sync <= {mosi_sync[0], debug_mosi};
            ss_prev   <= ss_sync[1];
            sclk_prev <= sclk_sync[1];
        end
    end

    assign ss_fall   = ss_prev & ~ss_sync[1];
    assign sclk_rise = ~sclk_prev & sclk_sync[1];
    assign sclk_fall = sclk_prev & ~sclk_sync[1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt     <= 3'd0;
            rx_q        <= 7'd0;
            tx_q        <= 8'd0;
            cmd_q       <= 8'd0;
            cmd_valid_q <= 1'b0;
        end else begin
            cmd_valid_q <= 1'b0;
            if (ss_fall) begin
                tx_q    <= reply; // first bit out before first rise
                bit_cnt <= 3'd0;
            end else if (!ss_sync[1]) begin
                if (sclk_rise) begin
                    rx_q    <= {rx_q[5:0], mosi_sync[1]};
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        cmd_q       <= {rx_q, mosi_sync[1]};
                        cmd_valid_q <= 1'b1;
                    end
                end
                if (sclk_fall) begin
                    tx_q <= {tx_q[6:0], 1'b0};
                end
            end
        end
    end

    assign debug_miso = ~ss_sync[1] & tx_q[7];
    assign cmd        = cmd_q;
    assign cmd_valid  = cmd_valid_q;

endmodule

/* debug/debug_regs.sv */
`timescale 1ns/1ps

module debug_regs (
    input  logic             clk,
    input  logic             arst_n,
    input  wave_pkg::frame_t frame,
    input  logic             debug_ss,
    input  logic [7:0]       phase,
    input  logic [7:0]       adc1,
    input  logic [7:0]       adc2,
    input  logic [7:0]       cmd,
    input  logic             cmd_valid,
    output logic [7:0]       reply
);

    wave_pkg::snap_t snap_q;
    logic [7:0]      reply_q;

    // frozen while a debug transaction is open
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            snap_q <= '0;
        end else if (frame.done && debug_ss) begin
            snap_q.phase <= phase;
            snap_q.adc1  <= adc1;
            snap_q.adc2  <= adc2;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reply_q <= 8'd0; // first reply after reset
        end else if (cmd_valid) begin
            case (wave_pkg::debug_cmd_e'(cmd[1:0]))
                wave_pkg::cmd_phase: reply_q <= snap_q.phase;
                wave_pkg::cmd_adc1:  reply_q <= snap_q.adc1;
                wave_pkg::cmd_adc2:  reply_q <= snap_q.adc2;
                default:             reply_q <= wave_pkg::debug_filler;
            endcase
        end
    end

    assign reply = reply_q;

endmodule

/* rtl/waveform_io_top.sv */
`timescale 1ns/1ps

module waveform_io_top (
    input  logic clk,
    input  logic arst_n,

    input  logic debug_ss,
    input  logic debug_sclk,
    input  logic debug_mosi,
    output logic debug_miso,

    output logic dac1_sync,
    output logic dac1_sclk,
    output logic dac1_mosi,

    output logic dac2_sync,
    output logic dac2_sclk,
    output logic dac2_mosi,

    output logic adc1_ss,
    output logic adc1_sclk,
    input  logic adc1_miso,
    output logic adc1_mosi,

    output logic adc2_ss,
    output logic adc2_sclk,
    input  logic adc2_miso,
    output logic adc2_mosi
);

    wave_pkg::frame_t frame;
    logic [7:0]       phase;
    logic [7:0]       sine;
    logic [7:0]       adc1_code;
    logic [7:0]       adc2_code;
    logic [7:0]       dbg_cmd;
    logic             dbg_cmd_valid;
    logic [7:0]       dbg_reply;

    spi_frame_ctrl u_frame (
        .clk    (clk),
        .arst_n (arst_n),
        .frame  (frame)
    );

    sine_phase_gen u_sine (
        .clk    (clk),
        .arst_n (arst_n),
        .frame  (frame),
        .phase  (phase),
        .sine   (sine)
    );

    // DAC sclk idles low, so it runs inverted
    assign dac1_sync = frame.ss;
    assign dac1_sclk = ~frame.sclk;
    assign dac2_sync = frame.ss;
    assign dac2_sclk = ~frame.sclk;

    dac_frame_shifter u_dac1 (
        .clk    (clk),
        .arst_n (arst_n),
        .frame  (frame),
        .code   ({sine, 4'h0}),
        .mosi   (dac1_mosi)
    );

    dac_frame_shifter u_dac2 (
        .clk    (clk),
        .arst_n (arst_n),
        .frame  (frame),
        .code   ({phase, 4'h0}), // ramp
        .mosi   (dac2_mosi)
    );

    assign adc1_ss   = frame.ss;
    assign adc1_sclk = frame.sclk;
    assign adc2_ss   = frame.ss;
    assign adc2_sclk = frame.sclk;

    adc_frame_sampler u_adc1 (
        .clk    (clk),
        .arst_n (arst_n),
        .frame  (frame),
        .miso   (adc1_miso),
        .mosi   (adc1_mosi),
        .code   (adc1_code)
    );

    adc_frame_sampler u_adc2 (
        .clk    (clk),
        .arst_n (arst_n),
        .frame  (frame),
        .miso   (adc2_miso),
        .mosi   (adc2_mosi),
        .code   (adc2_code)
    );

    debug_spi_slave u_dbg_slave (
        .clk        (clk),
        .arst_n     (arst_n),
        .debug_ss   (debug_ss),
        .debug_sclk (debug_sclk),
        .debug_mosi (debug_mosi),
        .debug_miso (debug_miso),
        .reply      (dbg_reply),
        .cmd        (dbg_cmd),
        .cmd_valid  (dbg_cmd_valid)
    );

    debug_regs u_dbg_regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .frame     (frame),
        .debug_ss  (debug_ss),
        .phase     (phase),
        .adc1      (adc1_code),
        .adc2      (adc2_code),
        .cmd       (dbg_cmd),
        .cmd_valid (dbg_cmd_valid),
        .reply     (dbg_reply)
    );

endmodule

/* testbench/tb_spi_models.sv */
`timescale 1ns/1ps

// ADC slave sending 4 zeros, 8 code bits and 4 zeros on miso, address taken from mosi
module adc_slave_model (
    input  logic       ss,
    input  logic       sclk,
    input  logic       mosi,
    input  logic [7:0] code,
    output logic       miso,
    output logic [7:0] code_sent,
    output logic [2:0] addr,
    output int         frames
);

    logic [15:0] tx_word = 16'd0;
    logic [15:0] rx_word = 16'd0;
    logic        miso_q = 1'b0;
    logic [7:0]  sent_q = 8'd0;
    logic [2:0]  addr_q = 3'd0;
    int          frames_q = 0;

    initial begin
        forever begin
            @(negedge ss);
            tx_word = {4'h0, code, 4'h0};
            sent_q  = code;
            miso_q  = tx_word[15]; // set up before first rise
            for (int i = 14; i >= -1; i--) begin
                @(posedge sclk);
                rx_word = {rx_word[14:0], mosi};
                if (i >= 0) begin
                    @(negedge sclk);
                    miso_q = tx_word[i];
                end
            end
            @(posedge ss);
            miso_q   = 1'b0;
            addr_q   = rx_word[13:11];
            frames_q = frames_q + 1;
        end
    end

    assign miso      = miso_q;
    assign code_sent = sent_q;
    assign addr      = addr_q;
    assign frames    = frames_q;

endmodule

// DAC word capture on falling dac sclk
module dac_capture (
    input  logic        sync,
    input  logic        sclk,
    input  logic        mosi,
    output logic [15:0] word,
    output int          frames
);

    logic [15:0] shift_q = 16'd0;
    logic [15:0] word_q = 16'd0;
    int          frames_q = 0;

    initial begin
        forever begin
            @(negedge sync);
            for (int i = 0; i < 16; i++) begin
                @(negedge sclk);
                shift_q = {shift_q[14:0], mosi};
            end
            @(posedge sync);
            word_q   = shift_q;
            frames_q = frames_q + 1;
        end
    end

    assign word   = word_q;
    assign frames = frames_q;

endmodule

/* testbench/tb_waveform_io_top.sv */
`timescale 1ns/1ps

module tb_waveform_io_top;

    localparam int clk_ns      = 20;
    localparam int frame_clks  = 2 * wave_pkg::sclk_half * wave_pkg::frame_bits
                                 + wave_pkg::frame_gap;
    localparam int tbl_n       = 12;
    localparam int run_frames  = 300;
    localparam int hold_frames = 3;
    localparam int max_frames  = tbl_n * 4 + run_frames + hold_frames + 50;

    logic clk;
    logic arst_n;
    logic debug_ss;
    logic debug_sclk;
    logic debug_mosi;
    logic debug_miso;
    logic dac1_sync, dac1_sclk, dac1_mosi;
    logic dac2_sync, dac2_sclk, dac2_mosi;
    logic adc1_ss, adc1_sclk, adc1_miso, adc1_mosi;
    logic adc2_ss, adc2_sclk, adc2_miso, adc2_mosi;

    logic [7:0]  adc1_code_in = 8'd0;
    logic [7:0]  adc2_code_in = 8'd0;
    logic [7:0]  adc1_sent, adc2_sent;
    logic [2:0]  adc1_addr, adc2_addr;
    int          adc1_frames, adc2_frames, dac1_frames, dac2_frames;
    logic [15:0] dac1_word, dac2_word;

    logic [31:0] lfsr_q = 32'h5c13_d17f;
    // command byte and the field its reply comes from (0 phase, 1 adc1, 2 adc2, 3 filler)
    logic [7:0]  cmd_tbl [0:tbl_n-1] = '{8'h00, 8'h01, 8'h02, 8'h03, 8'h40, 8'h81,
                                         8'hc2, 8'h7f, 8'h04, 8'h35, 8'h26, 8'hff};
    logic [1:0]  src_tbl [0:tbl_n-1] = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd0, 2'd1,
                                         2'd2, 2'd3, 2'd0, 2'd1, 2'd2, 2'd3};
    int          order [0:tbl_n-1];
    logic [7:0]  codes1 [0:max_frames-1];
    logic [7:0]  codes2 [0:max_frames-1];
    logic [7:0]  snap_phase = 8'd0;
    logic [7:0]  snap_adc1 = 8'd0;
    logic [7:0]  snap_adc2 = 8'd0;
    int          frame_cnt = 0;

    waveform_io_top u_dut (.*);

    adc_slave_model u_adc1_model (.ss(adc1_ss), .sclk(adc1_sclk), .mosi(adc1_mosi),
        .code(adc1_code_in), .miso(adc1_miso), .code_sent(adc1_sent), .addr(adc1_addr),
        .frames(adc1_frames));
    adc_slave_model u_adc2_model (.ss(adc2_ss), .sclk(adc2_sclk), .mosi(adc2_mosi),
        .code(adc2_code_in), .miso(adc2_miso), .code_sent(adc2_sent), .addr(adc2_addr),
        .frames(adc2_frames));
    dac_capture u_dac1_cap (.sync(dac1_sync), .sclk(dac1_sclk), .mosi(dac1_mosi),
        .word(dac1_word), .frames(dac1_frames));
    dac_capture u_dac2_cap (.sync(dac2_sync), .sclk(dac2_sclk), .mosi(dac2_mosi),
        .word(dac2_word), .frames(dac2_frames));

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = 8'd0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[6:0], lfsr_q[0]};
        end
    endtask

    function automatic logic [7:0] sine_expected(input logic [7:0] p);
        int quadrant;
        int q;
        int v;
        quadrant = int'(p) / 64;
        q = int'(p) % 64;
        if (quadrant == 1 || quadrant == 3) q = 64 - q;
        if (quadrant < 2) v = 128 + int'(wave_pkg::sine_quarter[q]);
        else v = 128 - int'(wave_pkg::sine_quarter[q]);
        if (v > 255) v = 255;
        return 8'(v);
    endfunction

    function automatic logic [7:0] target_of(input logic [1:0] src);
        case (src)
            2'd0:    return snap_phase;
            2'd1:    return snap_adc1;
            2'd2:    return snap_adc2;
            default: return 8'hab;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // mode 0 byte exchange at 8 clk per half period
    task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx);
        for (int i = 7; i >= 0; i--) begin
            @(negedge clk);
            debug_mosi = tx[i];
            repeat (8) @(negedge clk);
            rx[i] = debug_miso;
            debug_sclk = 1'b1;
            repeat (8) @(negedge clk);
            debug_sclk = 1'b0;
        end
    endtask

    task automatic release_debug();
        repeat (8) @(negedge clk);
        debug_ss = 1'b1;
        repeat (8) @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_ns / 2) clk = ~clk;
    end

    initial begin : watchdog
        #(max_frames * frame_clks * clk_ns);
        $display("watchdog expired before the tests finished");
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    // snapshot model at each frame done
    initial begin : snapshot_track
        @(posedge arst_n);
        adc1_code_in = codes1[0];
        adc2_code_in = codes2[0];
        forever begin
            repeat (wave_pkg::frame_bits) @(posedge adc1_sclk);
            @(posedge clk);
            @(posedge clk);
            if (debug_ss) begin
                snap_phase = 8'(frame_cnt);
                snap_adc1  = adc1_sent;
                snap_adc2  = adc2_sent;
            end
            frame_cnt++;
            if (frame_cnt < max_frames) begin
                adc1_code_in = codes1[frame_cnt];
                adc2_code_in = codes2[frame_cnt];
            end
        end
    end

    always @(dac2_frames) begin
        int n;
        @(negedge clk);
        n = dac2_frames - 1;
        check("dac2_mosi word", 32'(dac2_word), 32'({2'b00, 8'(n), 4'h0, 2'b00}));
    end

    always @(dac1_frames) begin
        int n;
        @(negedge clk);
        n = dac1_frames - 1;
        check("dac1_mosi word", 32'(dac1_word),
              32'({2'b00, sine_expected(8'(n)), 4'h0, 2'b00}));
    end

    always @(adc1_frames) begin
        @(negedge clk);
        check("adc1_mosi address", 32'(adc1_addr), 32'(3'b001));
    end

    always @(adc2_frames) begin
        @(negedge clk);
        check("adc2_mosi address", 32'(adc2_addr), 32'(3'b001));
    end

    initial begin : main
        logic [7:0] r;
        logic [7:0] rx;
        logic [7:0] prev;
        logic [7:0] target;
        int j;
        int tmp;
        arst_n     = 1'b0;
        debug_ss   = 1'b1;
        debug_sclk = 1'b0;
        debug_mosi = 1'b0;
        prev       = 8'd0; // reply register resets to zero
        for (int f = 0; f < max_frames; f++) begin
            take_bits(8, r);
            codes1[f] = r;
            take_bits(8, r);
            codes2[f] = r;
        end
        for (int i = 0; i < tbl_n; i++) order[i] = i;
        for (int i = tbl_n - 1; i > 0; i--) begin
            take_bits(8, r);
            j = int'(r) % (i + 1);
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check("dac1_sync", 32'(dac1_sync), 32'd1);
        check("dac2_sync", 32'(dac2_sync), 32'd1);
        check("adc1_ss", 32'(adc1_ss), 32'd1);
        check("adc2_ss", 32'(adc2_ss), 32'd1);
        check("dac1_mosi", 32'(dac1_mosi), 32'd0);
        check("dac2_mosi", 32'(dac2_mosi), 32'd0);
        check("adc1_mosi", 32'(adc1_mosi), 32'd0);
        check("adc2_mosi", 32'(adc2_mosi), 32'd0);
        check("debug_miso", 32'(debug_miso), 32'd0);

        for (int k = 0; k < tbl_n; k++) begin
            take_bits(7, r);
            repeat (int'(r)) @(negedge clk);
            debug_ss = 1'b0;
            target = target_of(src_tbl[order[k]]);
            shift_byte(cmd_tbl[order[k]], rx);
            release_debug();
            check("debug_miso reply", 32'(rx), 32'(prev));
            prev = target;
        end

        // adc1 read twice in one window while new conversions arrive
        @(negedge clk);
        debug_ss = 1'b0;
        target = snap_adc1;
        shift_byte(8'h01, rx);
        check("debug_miso reply", 32'(rx), 32'(prev));
        repeat (hold_frames * frame_clks) @(negedge clk);
        shift_byte(8'h01, rx);
        release_debug();
        prev = target;
        debug_ss = 1'b0;
        shift_byte(8'h03, rx);
        release_debug();
        check("debug_miso held reply", 32'(rx), 32'(prev));

        wait (dac1_frames >= run_frames && dac2_frames >= run_frames);
        repeat (2) @(negedge clk);
        $display("TEST OK");
        $finish;
    end

endmodule

/* waveform_io_top.f */
common/wave_pkg.sv
spi_frame/spi_frame_ctrl.sv
rtl/sine_phase_gen.sv
rtl/dac_frame_shifter.sv
rtl/adc_frame_sampler.sv
debug/debug_spi_slave.sv
debug/debug_regs.sv
rtl/waveform_io_top.sv
testbench/tb_spi_models.sv
testbench/tb_waveform_io_top.sv

/* Makefile */
TOP = tb_waveform_io_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -j 0 --top-module $(TOP) -f waveform_io_top.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^TEST OK$$'

clean:
	rm -rf obj_dir
